// File: src/warp_sched_cfg.svh
`ifndef WARP_SCHED_CFG_SVH
`define WARP_SCHED_CFG_SVH

// warps held by the scheduler
`define WS_NUM_WARPS 8

// lanes per warp
`define WS_NUM_THREADS 4

`define WS_PC_WIDTH 32

// local barriers shared by all warps
`define WS_NUM_BARRIERS 4

// per-warp pending instruction counter
`define WS_CTR_WIDTH 8

// reset pc of warp 0
`define WS_STARTUP_ADDR 32'h8000_0000

`endif

// File: src/warp_sched_pkg.sv
`default_nettype none

`include "warp_sched_cfg.svh"

package warp_sched_pkg;

    localparam int NUM_WARPS    = `WS_NUM_WARPS;
    localparam int NUM_THREADS  = `WS_NUM_THREADS;
    localparam int PC_WIDTH     = `WS_PC_WIDTH;
    localparam int NUM_BARRIERS = `WS_NUM_BARRIERS;
    localparam int CTR_WIDTH    = `WS_CTR_WIDTH;
    localparam int WID_WIDTH    = $clog2(NUM_WARPS);
    localparam int BAR_WIDTH    = $clog2(NUM_BARRIERS);

    // sum of all per-warp counters
    localparam int PEND_WIDTH   = CTR_WIDTH + WID_WIDTH;

    typedef logic [WID_WIDTH-1:0]   wid_t;
    typedef logic [NUM_THREADS-1:0] tmask_t;
    typedef logic [NUM_WARPS-1:0]   wmask_t;
    typedef logic [PC_WIDTH-1:0]    pc_t;
    typedef logic [BAR_WIDTH-1:0]   bar_id_t;
    typedef logic [CTR_WIDTH-1:0]   ctr_t;
    typedef logic [PEND_WIDTH-1:0]  pend_t;

    typedef logic [7:0]  axil_addr_t;
    typedef logic [31:0] axil_data_t;

    // record handed to the fetch stage
    typedef struct packed {
        wid_t   wid;
        tmask_t tmask;
        pc_t    pc;
    } sched_item_t;

    typedef struct packed {
        axil_data_t data;
        logic [1:0] resp;
    } axil_rsp_t;

    typedef enum logic [1:0] {
        CMD_NONE,
        CMD_SPAWN,
        CMD_TMC,
        CMD_BARRIER
    } ctl_cmd_e;

    localparam axil_addr_t REG_SPAWN_PC = 8'h00;
    localparam axil_addr_t REG_SPAWN    = 8'h04;
    localparam axil_addr_t REG_TMC      = 8'h08;
    localparam axil_addr_t REG_BARRIER  = 8'h0C;
    localparam axil_addr_t REG_STATUS   = 8'h10;
    localparam axil_addr_t REG_PENDING  = 8'h14;

    localparam logic [1:0] RESP_OKAY    = 2'b00;
    localparam logic [1:0] RESP_SLVERR  = 2'b10;

endpackage

`default_nettype wire

// File: src/skid_buf.sv
`timescale 1ns/1ps
`default_nettype none

module skid_buf #(
    parameter type payload_t = logic [31:0]
) (
    input  wire           clk,
    input  wire           reset,
    input  wire           in_valid,
    output logic          in_ready,
    input  wire payload_t in_data,
    output logic          out_valid,
    input  wire           out_ready,
    output payload_t      out_data
);

    logic     skid_valid;
    payload_t skid_data;
    logic     out_free;

    // output slot can take a new entry this cycle
    assign out_free = !out_valid || out_ready;

    // only a full skid slot blocks the input
    assign in_ready = !skid_valid;

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid  <= 1'b0;
            skid_valid <= 1'b0;
        end else if (out_free) begin
            // skid entry moves first, input is blocked while it is held
            out_valid  <= skid_valid || in_valid;
            skid_valid <= 1'b0;
        end else if (in_valid && in_ready) begin
            skid_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (out_free) begin
            out_data <= skid_valid ? skid_data : in_data;
        end
        if (in_ready) begin
            skid_data <= in_data;
        end
    end

    // held data must not change under back-pressure
    stable_out_a: assert property (@(posedge clk) disable iff (reset)
        out_valid && !out_ready |=> out_valid && $stable(out_data));

endmodule

`default_nettype wire

// File: src/warp_ctl_axil.sv
`timescale 1ns/1ps
`default_nettype none

module warp_ctl_axil (
    input  wire                             clk,
    input  wire                             reset,
    input  wire warp_sched_pkg::axil_addr_t awaddr,
    input  wire                             awvalid,
    output logic                            awready,
    input  wire warp_sched_pkg::axil_data_t wdata,
    input  wire                             wvalid,
    output logic                            wready,
    output logic [1:0]                      bresp,
    output logic                            bvalid,
    input  wire                             bready,
    input  wire warp_sched_pkg::axil_addr_t araddr,
    input  wire                             arvalid,
    output logic                            arready,
    output warp_sched_pkg::axil_data_t      rdata,
    output logic [1:0]                      rresp,
    output logic                            rvalid,
    input  wire                             rready,
    output warp_sched_pkg::ctl_cmd_e        cmd_kind,
    output warp_sched_pkg::wid_t            cmd_wid,
    output warp_sched_pkg::wmask_t          cmd_wmask,
    output warp_sched_pkg::tmask_t          cmd_tmask,
    output warp_sched_pkg::pc_t             cmd_pc,
    output warp_sched_pkg::bar_id_t         cmd_bar_id,
    output warp_sched_pkg::wid_t            cmd_bar_size_m1,
    input  wire warp_sched_pkg::wmask_t     active_warps,
    input  wire                             busy,
    input  wire warp_sched_pkg::pend_t      pending_total
);
    import warp_sched_pkg::*;

    logic      wr_fire;
    logic      wr_known;
    ctl_cmd_e  wr_kind;
    pc_t       spawn_pc;
    axil_rsp_t rd_rsp;
    axil_rsp_t rd_out;

    // aw and w are taken together, one write in flight at a time
    assign wr_fire = awvalid && wvalid && !bvalid;
    assign awready = wr_fire;
    assign wready  = wr_fire;

    always_comb begin
        wr_kind  = CMD_NONE;
        wr_known = 1'b1;
        case (awaddr)
            REG_SPAWN_PC: wr_kind = CMD_NONE;
            REG_SPAWN:    wr_kind = CMD_SPAWN;
            REG_TMC:      wr_kind = CMD_TMC;
            REG_BARRIER:  wr_kind = CMD_BARRIER;
            default:      wr_known = 1'b0;
        endcase
    end

    // command pulse and write response start together
    always_ff @(posedge clk) begin
        if (reset) begin
            cmd_kind <= CMD_NONE;
            bvalid   <= 1'b0;
            bresp    <= RESP_OKAY;
        end else begin
            cmd_kind <= wr_fire ? wr_kind : CMD_NONE;
            if (wr_fire) begin
                bvalid <= 1'b1;
                bresp  <= wr_known ? RESP_OKAY : RESP_SLVERR;
            end else if (bready) begin
                bvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_fire) begin
            cmd_wmask       <= wdata[NUM_WARPS-1:0];
            cmd_tmask       <= wdata[NUM_THREADS-1:0];
            cmd_bar_id      <= wdata[16 +: BAR_WIDTH];
            cmd_bar_size_m1 <= wdata[8 +: WID_WIDTH];
            // tmc keeps its wid in the second byte, barrier in the first
            if (awaddr == REG_TMC) begin
                cmd_wid <= wdata[8 +: WID_WIDTH];
            end else begin
                cmd_wid <= wdata[WID_WIDTH-1:0];
            end
            if (awaddr == REG_SPAWN_PC) begin
                spawn_pc <= wdata[PC_WIDTH-1:0];
            end
        end
    end

    assign cmd_pc = spawn_pc;

    // status read mux
    always_comb begin
        rd_rsp.data = '0;
        rd_rsp.resp = RESP_OKAY;
        case (araddr)
            REG_STATUS: begin
                rd_rsp.data[NUM_WARPS-1:0] = active_warps;
                rd_rsp.data[31]            = busy;
            end
            REG_PENDING: rd_rsp.data[PEND_WIDTH-1:0] = pending_total;
            default:     rd_rsp.resp = RESP_SLVERR;
        endcase
    end

    skid_buf #(
        .payload_t (axil_rsp_t)
    ) rsp_buf_inst (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (arvalid),
        .in_ready  (arready),
        .in_data   (rd_rsp),
        .out_valid (rvalid),
        .out_ready (rready),
        .out_data  (rd_out)
    );

    assign rdata = rd_out.data;
    assign rresp = rd_out.resp;

    // every command rides on a write response and never repeats
    cmd_pulse_a: assert property (@(posedge clk) disable iff (reset)
        cmd_kind != CMD_NONE |-> bvalid ##1 cmd_kind == CMD_NONE);

endmodule

`default_nettype wire

// File: src/warp_state.sv
`timescale 1ns/1ps
`default_nettype none

`include "warp_sched_cfg.svh"

module warp_state (
    input  wire                            clk,
    input  wire                            reset,
    input  wire warp_sched_pkg::ctl_cmd_e  cmd_kind,
    input  wire warp_sched_pkg::wid_t      cmd_wid,
    input  wire warp_sched_pkg::wmask_t    cmd_wmask,
    input  wire warp_sched_pkg::tmask_t    cmd_tmask,
    input  wire warp_sched_pkg::pc_t       cmd_pc,
    input  wire warp_sched_pkg::bar_id_t   cmd_bar_id,
    input  wire warp_sched_pkg::wid_t      cmd_bar_size_m1,
    input  wire                            dec_valid,
    input  wire warp_sched_pkg::wid_t      dec_wid,
    output logic                           sel_valid,
    output warp_sched_pkg::sched_item_t    sel_item,
    input  wire                            sel_ready,
    input  wire                            out_fire,
    input  wire warp_sched_pkg::wid_t      out_wid,
    output warp_sched_pkg::wmask_t         active_warps
);
    import warp_sched_pkg::*;

    wmask_t active_n;
    wmask_t stalled;
    wmask_t stalled_n;
    wmask_t bar_stalls;
    wmask_t bar_stalls_n;
    tmask_t tmasks [NUM_WARPS];
    tmask_t tmasks_n [NUM_WARPS];
    pc_t    pcs [NUM_WARPS];
    pc_t    pcs_n [NUM_WARPS];
    wmask_t bar_masks [NUM_BARRIERS];
    wmask_t bar_masks_n [NUM_BARRIERS];
    wmask_t ready_warps;
    wid_t   sel_wid;
    logic   sel_fire;
    int     bar_count;

    assign sel_fire  = sel_valid && sel_ready;
    assign bar_count = $countones(bar_masks[cmd_bar_id]);

    always_comb begin
        active_n     = active_warps;
        stalled_n    = stalled;
        bar_stalls_n = bar_stalls;
        tmasks_n     = tmasks;
        pcs_n        = pcs;
        bar_masks_n  = bar_masks;

        case (cmd_kind)
            CMD_SPAWN: begin
                for (int i = 0; i < NUM_WARPS; i++) begin
                    if (cmd_wmask[i]) begin
                        active_n[i] = 1'b1;
                        tmasks_n[i] = tmask_t'(1);
                        pcs_n[i]    = cmd_pc;
                    end
                end
            end
            CMD_TMC: begin
                // empty mask retires the warp
                active_n[cmd_wid] = (cmd_tmask != '0);
                tmasks_n[cmd_wid] = cmd_tmask;
            end
            CMD_BARRIER: begin
                if (bar_count == int'(cmd_bar_size_m1)) begin
                    // last arrival frees everyone waiting
                    bar_masks_n[cmd_bar_id] = '0;
                    bar_stalls_n            = bar_stalls & ~bar_masks[cmd_bar_id];
                end else begin
                    bar_masks_n[cmd_bar_id][cmd_wid] = 1'b1;
                    bar_stalls_n[cmd_wid]            = 1'b1;
                end
            end
            default: ;
        endcase

        if (dec_valid) begin
            stalled_n[dec_wid] = 1'b0;
        end
        // stall wins over an unlock of the same warp
        if (sel_fire) begin
            stalled_n[sel_wid] = 1'b1;
        end
        if (out_fire) begin
            pcs_n[out_wid] = pcs[out_wid] + pc_t'(4);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            active_warps <= wmask_t'(1);
            stalled      <= '0;
            bar_stalls   <= '0;
            for (int i = 0; i < NUM_WARPS; i++) begin
                tmasks[i] <= (i == 0) ? tmask_t'(1) : '0;
                pcs[i]    <= (i == 0) ? pc_t'(`WS_STARTUP_ADDR) : '0;
            end
            for (int b = 0; b < NUM_BARRIERS; b++) begin
                bar_masks[b] <= '0;
            end
        end else begin
            active_warps <= active_n;
            stalled      <= stalled_n;
            bar_stalls   <= bar_stalls_n;
            tmasks       <= tmasks_n;
            pcs          <= pcs_n;
            bar_masks    <= bar_masks_n;
        end
    end

    assign ready_warps = active_warps & ~(stalled | bar_stalls);

    // lowest ready index wins
    always_comb begin
        sel_wid = '0;
        for (int i = NUM_WARPS - 1; i >= 0; i--) begin
            if (ready_warps[i]) begin
                sel_wid = wid_t'(i);
            end
        end
    end

    assign sel_valid      = (ready_warps != '0);
    assign sel_item.wid   = sel_wid;
    assign sel_item.tmask = tmasks[sel_wid];
    assign sel_item.pc    = pcs[sel_wid];

    // an issued warp is locked out until decode releases it
    no_reissue_a: assert property (@(posedge clk) disable iff (reset)
        sel_fire |=> !(sel_valid && sel_wid == $past(sel_wid)));

endmodule

`default_nettype wire

// File: src/pending_counter.sv
`timescale 1ns/1ps
`default_nettype none

module pending_counter (
    input  wire                         clk,
    input  wire                         reset,
    input  wire                         incr,
    input  wire warp_sched_pkg::wid_t   incr_wid,
    input  wire                         decr,
    input  wire warp_sched_pkg::wid_t   decr_wid,
    input  wire warp_sched_pkg::wmask_t active_warps,
    output warp_sched_pkg::pend_t       pending_total,
    output logic                        busy
);
    import warp_sched_pkg::*;

    ctr_t   ctrs [NUM_WARPS];
    wmask_t inc_hit;
    wmask_t dec_hit;
    wmask_t nonzero;

    always_comb begin
        for (int i = 0; i < NUM_WARPS; i++) begin
            inc_hit[i] = incr && (incr_wid == wid_t'(i));
            dec_hit[i] = decr && (decr_wid == wid_t'(i));
            nonzero[i] = (ctrs[i] != '0);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < NUM_WARPS; i++) begin
                ctrs[i] <= '0;
            end
            pending_total <= '0;
            busy          <= 1'b0;
        end else begin
            // issue and commit on the same warp cancel out
            for (int i = 0; i < NUM_WARPS; i++) begin
                case ({inc_hit[i], dec_hit[i]})
                    2'b10:   ctrs[i] <= ctrs[i] + 1'b1;
                    2'b01:   ctrs[i] <= ctrs[i] - 1'b1;
                    default: ;
                endcase
            end
            case ({incr, decr})
                2'b10:   pending_total <= pending_total + 1'b1;
                2'b01:   pending_total <= pending_total - 1'b1;
                default: ;
            endcase
            busy <= (active_warps != '0) || (nonzero != '0);
        end
    end

    // commits only follow earlier issues of the same warp
    no_underflow_a: assert property (@(posedge clk) disable iff (reset)
        decr |-> ctrs[decr_wid] != '0 || (incr && incr_wid == decr_wid));

endmodule

`default_nettype wire

// File: src/warp_sched_top.sv
`timescale 1ns/1ps
`default_nettype none

module warp_sched_top (
    input  wire                             clk,
    input  wire                             reset,
    input  wire warp_sched_pkg::axil_addr_t awaddr,
    input  wire                             awvalid,
    output logic                            awready,
    input  wire warp_sched_pkg::axil_data_t wdata,
    input  wire                             wvalid,
    output logic                            wready,
    output logic [1:0]                      bresp,
    output logic                            bvalid,
    input  wire                             bready,
    input  wire warp_sched_pkg::axil_addr_t araddr,
    input  wire                             arvalid,
    output logic                            arready,
    output warp_sched_pkg::axil_data_t      rdata,
    output logic [1:0]                      rresp,
    output logic                            rvalid,
    input  wire                             rready,
    output logic                            issue_valid,
    input  wire                             issue_ready,
    output warp_sched_pkg::wid_t            issue_wid,
    output warp_sched_pkg::tmask_t          issue_tmask,
    output warp_sched_pkg::pc_t             issue_pc,
    input  wire                             dec_valid,
    input  wire warp_sched_pkg::wid_t       dec_wid,
    input  wire                             commit_valid,
    input  wire warp_sched_pkg::wid_t       commit_wid,
    output logic                            busy
);
    import warp_sched_pkg::*;

    ctl_cmd_e    cmd_kind;
    wid_t        cmd_wid;
    wmask_t      cmd_wmask;
    tmask_t      cmd_tmask;
    pc_t         cmd_pc;
    bar_id_t     cmd_bar_id;
    wid_t        cmd_bar_size_m1;
    logic        sel_valid;
    logic        sel_ready;
    sched_item_t sel_item;
    sched_item_t issue_item;
    logic        issue_fire;
    wmask_t      active_warps;
    pend_t       pending_total;

    assign issue_fire  = issue_valid && issue_ready;
    assign issue_wid   = issue_item.wid;
    assign issue_tmask = issue_item.tmask;
    assign issue_pc    = issue_item.pc;

    warp_ctl_axil ctl_inst (
        .clk             (clk),
        .reset           (reset),
        .awaddr          (awaddr),
        .awvalid         (awvalid),
        .awready         (awready),
        .wdata           (wdata),
        .wvalid          (wvalid),
        .wready          (wready),
        .bresp           (bresp),
        .bvalid          (bvalid),
        .bready          (bready),
        .araddr          (araddr),
        .arvalid         (arvalid),
        .arready         (arready),
        .rdata           (rdata),
        .rresp           (rresp),
        .rvalid          (rvalid),
        .rready          (rready),
        .cmd_kind        (cmd_kind),
        .cmd_wid         (cmd_wid),
        .cmd_wmask       (cmd_wmask),
        .cmd_tmask       (cmd_tmask),
        .cmd_pc          (cmd_pc),
        .cmd_bar_id      (cmd_bar_id),
        .cmd_bar_size_m1 (cmd_bar_size_m1),
        .active_warps    (active_warps),
        .busy            (busy),
        .pending_total   (pending_total)
    );

    warp_state state_inst (
        .clk             (clk),
        .reset           (reset),
        .cmd_kind        (cmd_kind),
        .cmd_wid         (cmd_wid),
        .cmd_wmask       (cmd_wmask),
        .cmd_tmask       (cmd_tmask),
        .cmd_pc          (cmd_pc),
        .cmd_bar_id      (cmd_bar_id),
        .cmd_bar_size_m1 (cmd_bar_size_m1),
        .dec_valid       (dec_valid),
        .dec_wid         (dec_wid),
        .sel_valid       (sel_valid),
        .sel_item        (sel_item),
        .sel_ready       (sel_ready),
        .out_fire        (issue_fire),
        .out_wid         (issue_item.wid),
        .active_warps    (active_warps)
    );

    // issue path to fetch
    skid_buf #(
        .payload_t (sched_item_t)
    ) issue_buf_inst (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (sel_valid),
        .in_ready  (sel_ready),
        .in_data   (sel_item),
        .out_valid (issue_valid),
        .out_ready (issue_ready),
        .out_data  (issue_item)
    );

    pending_counter pending_inst (
        .clk           (clk),
        .reset         (reset),
        .incr          (issue_fire),
        .incr_wid      (issue_item.wid),
        .decr          (commit_valid),
        .decr_wid      (commit_wid),
        .active_warps  (active_warps),
        .pending_total (pending_total),
        .busy          (busy)
    );

endmodule

`default_nettype wire

// File: verif/warp_sched_checker.sv
`timescale 1ns/1ps
`default_nettype none

module warp_sched_checker (
    input wire                             clk,
    input wire                             reset,
    input wire                             issue_valid,
    input wire                             issue_ready,
    input wire warp_sched_pkg::wid_t       issue_wid,
    input wire warp_sched_pkg::tmask_t     issue_tmask,
    input wire warp_sched_pkg::pc_t        issue_pc,
    input wire                             bvalid,
    input wire                             bready,
    input wire [1:0]                       bresp,
    input wire                             rvalid,
    input wire                             rready,
    input wire warp_sched_pkg::axil_data_t rdata,
    input wire [1:0]                       rresp,
    input wire                             busy
);
    import warp_sched_pkg::*;

    sched_item_t exp_issue [$];
    axil_rsp_t   exp_read [$];
    logic [1:0]  exp_bresp [$];
    int          mismatch_count = 0;
    int          unexpected_count = 0;
    logic        was_reset = 1'b1;

    task automatic expect_issue(input wid_t wid, input tmask_t tmask, input pc_t pc);
        sched_item_t item;
        item.wid   = wid;
        item.tmask = tmask;
        item.pc    = pc;
        exp_issue.push_back(item);
    endtask

    task automatic expect_read(input axil_data_t data, input logic [1:0] resp);
        axil_rsp_t rsp;
        rsp.data = data;
        rsp.resp = resp;
        exp_read.push_back(rsp);
    endtask

    task automatic expect_bresp(input logic [1:0] resp);
        exp_bresp.push_back(resp);
    endtask

    function automatic int outstanding();
        return exp_issue.size() + exp_read.size() + exp_bresp.size();
    endfunction

    task automatic compare_value(input string name, input logic [31:0] exp,
                                 input logic [31:0] got);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s expected %h got %h", $time, name, exp, got);
            mismatch_count++;
        end
    endtask

    always @(posedge clk) begin : watch
        sched_item_t item;
        axil_rsp_t   rsp;
        logic [1:0]  resp;
        if (reset) begin
            was_reset = 1'b1;
        end else begin
            // outputs must come out of reset idle
            if (was_reset) begin
                compare_value("bvalid", 32'd0, 32'(bvalid));
                compare_value("rvalid", 32'd0, 32'(rvalid));
                compare_value("issue_valid", 32'd0, 32'(issue_valid));
                compare_value("busy", 32'd0, 32'(busy));
            end
            was_reset = 1'b0;
            if (issue_valid && issue_ready) begin
                if (exp_issue.size() == 0) begin
                    $display("Unexpected issue of warp %0d at pc %h at %0t",
                             issue_wid, issue_pc, $time);
                    unexpected_count++;
                end else begin
                    item = exp_issue.pop_front();
                    compare_value("issue_wid", 32'(item.wid), 32'(issue_wid));
                    compare_value("issue_tmask", 32'(item.tmask), 32'(issue_tmask));
                    compare_value("issue_pc", item.pc, issue_pc);
                end
            end
            if (rvalid && rready) begin
                if (exp_read.size() == 0) begin
                    $display("Unexpected read response at %0t", $time);
                    unexpected_count++;
                end else begin
                    rsp = exp_read.pop_front();
                    compare_value("rdata", rsp.data, rdata);
                    compare_value("rresp", 32'(rsp.resp), 32'(rresp));
                end
            end
            if (bvalid && bready) begin
                if (exp_bresp.size() == 0) begin
                    $display("Unexpected write response at %0t", $time);
                    unexpected_count++;
                end else begin
                    resp = exp_bresp.pop_front();
                    compare_value("bresp", 32'(resp), 32'(bresp));
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: verif/tb_warp_sched.sv
`timescale 1ns/1ps
`default_nettype none

module tb_warp_sched;
    import warp_sched_pkg::*;

    localparam int WAIT_LIMIT = 400;

    logic        clk;
    logic        reset;
    axil_addr_t  awaddr;
    logic        awvalid;
    logic        awready;
    axil_data_t  wdata;
    logic        wvalid;
    logic        wready;
    logic [1:0]  bresp;
    logic        bvalid;
    logic        bready;
    axil_addr_t  araddr;
    logic        arvalid;
    logic        arready;
    axil_data_t  rdata;
    logic [1:0]  rresp;
    logic        rvalid;
    logic        rready;
    logic        issue_valid;
    logic        issue_ready;
    wid_t        issue_wid;
    tmask_t      issue_tmask;
    pc_t         issue_pc;
    logic        dec_valid;
    wid_t        dec_wid;
    logic        commit_valid;
    wid_t        commit_wid;
    logic        busy;
    logic        random_ready;
    logic [31:0] rnd;
    int          timeout_count;
    logic        aborted;
    logic        file_ok;
    int          fd;
    int          code;
    string       line;
    byte         cmd;
    logic [31:0] a0;
    logic [31:0] a1;
    logic [31:0] a2;
    logic [31:0] unlock_q [$];

    warp_sched_top warp_sched_top_inst (
        .clk          (clk),
        .reset        (reset),
        .awaddr       (awaddr),
        .awvalid      (awvalid),
        .awready      (awready),
        .wdata        (wdata),
        .wvalid       (wvalid),
        .wready       (wready),
        .bresp        (bresp),
        .bvalid       (bvalid),
        .bready       (bready),
        .araddr       (araddr),
        .arvalid      (arvalid),
        .arready      (arready),
        .rdata        (rdata),
        .rresp        (rresp),
        .rvalid       (rvalid),
        .rready       (rready),
        .issue_valid  (issue_valid),
        .issue_ready  (issue_ready),
        .issue_wid    (issue_wid),
        .issue_tmask  (issue_tmask),
        .issue_pc     (issue_pc),
        .dec_valid    (dec_valid),
        .dec_wid      (dec_wid),
        .commit_valid (commit_valid),
        .commit_wid   (commit_wid),
        .busy         (busy)
    );

    warp_sched_checker checker_inst (
        .clk         (clk),
        .reset       (reset),
        .issue_valid (issue_valid),
        .issue_ready (issue_ready),
        .issue_wid   (issue_wid),
        .issue_tmask (issue_tmask),
        .issue_pc    (issue_pc),
        .bvalid      (bvalid),
        .bready      (bready),
        .bresp       (bresp),
        .rvalid      (rvalid),
        .rready      (rready),
        .rdata       (rdata),
        .rresp       (rresp),
        .busy        (busy)
    );

    always #2 clk = ~clk;

    // fetch back-pressure, random only when the stim asks for it
    always @(posedge clk) begin
        #1;
        rnd = $urandom;
        issue_ready = random_ready ? rnd[0] : 1'b1;
    end

    task automatic report_timeout(input string what);
        $display("Timeout at %0t while waiting for %s", $time, what);
        timeout_count++;
        aborted = 1'b1;
    endtask

    task automatic wait_for_checker(input string what);
        int waited;
        waited = 0;
        while (checker_inst.outstanding() != 0 && waited < WAIT_LIMIT) begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (checker_inst.outstanding() != 0) begin
            report_timeout(what);
        end
    endtask

    task automatic axil_write(input logic [31:0] addr, input logic [31:0] data,
                              input logic [31:0] resp);
        int waited;
        checker_inst.expect_bresp(resp[1:0]);
        awaddr  = addr[7:0];
        wdata   = data;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        waited  = 0;
        @(negedge clk);
        while (!(awready && wready) && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (!(awready && wready)) begin
            awvalid = 1'b0;
            wvalid  = 1'b0;
            report_timeout("write address acceptance");
        end else begin
            @(posedge clk);
            #1;
            awvalid = 1'b0;
            wvalid  = 1'b0;
            wait_for_checker("write response");
        end
    endtask

    task automatic axil_read(input logic [31:0] addr, input logic [31:0] data,
                             input logic [31:0] resp);
        int waited;
        checker_inst.expect_read(data, resp[1:0]);
        araddr  = addr[7:0];
        arvalid = 1'b1;
        waited  = 0;
        @(negedge clk);
        while (!arready && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (!arready) begin
            arvalid = 1'b0;
            report_timeout("read address acceptance");
        end else begin
            @(posedge clk);
            #1;
            arvalid = 1'b0;
            wait_for_checker("read response");
        end
    endtask

    task automatic pulse_unlock(input logic [31:0] wid);
        dec_valid = 1'b1;
        dec_wid   = wid[WID_WIDTH-1:0];
        @(posedge clk);
        #1;
        dec_valid = 1'b0;
    endtask

    task automatic send_unlocks();
        while (unlock_q.size() != 0) begin
            pulse_unlock(unlock_q.pop_front());
        end
    endtask

    task automatic pulse_commits(input logic [31:0] wid, input logic [31:0] count);
        for (int i = 0; i < int'(count); i++) begin
            commit_valid = 1'b1;
            commit_wid   = wid[WID_WIDTH-1:0];
            @(posedge clk);
            #1;
        end
        commit_valid = 1'b0;
    endtask

    initial begin
        void'($urandom(32'h4168_525f));
        clk           = 1'b0;
        reset         = 1'b1;
        awaddr        = '0;
        awvalid       = 1'b0;
        wdata         = '0;
        wvalid        = 1'b0;
        bready        = 1'b1;
        araddr        = '0;
        arvalid       = 1'b0;
        rready        = 1'b1;
        issue_ready   = 1'b1;
        dec_valid     = 1'b0;
        dec_wid       = '0;
        commit_valid  = 1'b0;
        commit_wid    = '0;
        random_ready  = 1'b0;
        timeout_count = 0;
        aborted       = 1'b0;
        file_ok       = 1'b1;
        repeat (16) @(posedge clk);
        #1;
        reset = 1'b0;

        fd = $fopen("verif/warp_sched_stim.txt", "r");
        if (fd == 0) begin
            $display("Could not open the stimulus file verif/warp_sched_stim.txt");
            file_ok = 1'b0;
        end else begin
            while (!$feof(fd) && !aborted) begin
                line = "";
                cmd  = " ";
                code = $fgets(line, fd);
                code = $sscanf(line, "%c %h %h %h", cmd, a0, a1, a2);
                // unlocks wait until the expected issues listed after them are queued
                if (cmd != "D" && cmd != "I") begin
                    send_unlocks();
                end
                case (cmd)
                    "W": axil_write(a0, a1, a2);
                    "R": axil_read(a0, a1, a2);
                    "I": checker_inst.expect_issue(a0[WID_WIDTH-1:0],
                                                   a1[NUM_THREADS-1:0], a2);
                    "X": wait_for_checker("expected issue records");
                    "D": unlock_q.push_back(a0);
                    "C": pulse_commits(a0, a1);
                    "P": random_ready = a0[0];
                    "N": begin
                        repeat (int'(a0)) begin
                            @(posedge clk);
                            #1;
                        end
                    end
                    default: ;
                endcase
            end
            $fclose(fd);
            if (!aborted) begin
                send_unlocks();
                wait_for_checker("remaining expected responses");
            end
        end

        $display("errors: %0d mismatches, %0d unexpected, %0d timeouts",
                 checker_inst.mismatch_count, checker_inst.unexpected_count,
                 timeout_count);
        if (file_ok && timeout_count == 0 && checker_inst.mismatch_count == 0
                && checker_inst.unexpected_count == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: compile.f
+incdir+src
src/warp_sched_pkg.sv
src/skid_buf.sv
src/warp_ctl_axil.sv
src/warp_state.sv
src/pending_counter.sv
src/warp_sched_top.sv
verif/warp_sched_checker.sv
verif/tb_warp_sched.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_warp_sched
FLIST     ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert -Wno-fatal

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FLIST) --top-module $(TOP)

$(BUILD_DIR)/V$(TOP): $(FLIST)
	$(VERILATOR) --binary $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

sim: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "\*\*\* TEST PASSED \*\*\*" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: verif/warp_sched_stim.txt
# W addr data bresp | R addr rdata rresp | I wid tmask pc | X wait for expected
# D wid unlock | C wid count commits | N cycles idle | P 1 random issue_ready
I 0 1 80000000
X
N 10
D 0
I 0 1 80000004
X
W 00 00001000 0
W 04 00000006 0
I 1 1 00001000
I 2 1 00001000
X
D 0
D 1
D 2
I 0 1 80000008
I 1 1 00001004
I 2 1 00001004
X
D 0
D 1
D 2
I 0 1 8000000c
I 1 1 00001008
I 2 1 00001008
X
W 08 0000010f 0
D 1
I 1 f 0000100c
X
W 08 00000200 0
D 2
N 8
R 10 80000003 0
W 0c 00000100 0
D 0
N 8
W 0c 00000101 0
I 0 1 80000010
X
P 1
D 0
D 1
I 0 1 80000014
I 1 f 00001010
X
D 0
D 1
I 0 1 80000018
I 1 f 00001014
X
R 14 00000010 0
C 2 3
R 14 0000000d 0
R 10 80000003 0
C 1 6
C 0 7
R 14 00000000 0
W 08 00000000 0
W 08 00000100 0
N 3
R 10 00000000 0
W 20 00000000 2
R 18 00000000 2
